//--- logic/video_pkg.sv
`default_nettype none

package video_pkg;

	// horizontal raster, in pixel clocks
	localparam int h_active = 640;
	localparam int h_front  = 16;
	localparam int h_sync   = 96;
	localparam int h_back   = 48;
	localparam int h_total  = h_active + h_front + h_sync + h_back;

	// vertical raster, in lines
	localparam int v_active = 480;
	localparam int v_front  = 10;
	localparam int v_sync   = 2;
	localparam int v_back   = 33;
	localparam int v_total  = v_active + v_front + v_sync + v_back;

	// sync pulse windows, start inclusive and end exclusive
	localparam int h_sync_start = h_active + h_front;
	localparam int h_sync_end   = h_sync_start + h_sync;
	localparam int v_sync_start = v_active + v_front;
	localparam int v_sync_end   = v_sync_start + v_sync;

	// one raster position with its timing flags
	// both syncs are active low
	typedef struct packed {
		logic [9:0] x;
		logic [9:0] y;
		logic       active;
		logic       hsync;
		logic       vsync;
	} scan_t;

	// what leaves the chip on the vga connector
	typedef struct packed {
		logic       hsync;
		logic       vsync;
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} pixel_t;

endpackage

`default_nettype wire

//--- logic/board_pkg.sv
`default_nettype none

package board_pkg;

	// 8 by 8 board placed inside the 640x480 picture
	localparam int board_cells = 64;
	localparam int board_dim   = 8;
	localparam int board_x0    = 128;
	localparam int board_y0    = 48;
	localparam int cell_px     = 48;
	localparam int line_px     = 2;

	// side of the board square in pixels
	localparam int board_span = board_dim * cell_px;

	// per cell colour code as written by the game
	typedef logic [1:0] cell_code_t;

	// 24-bit colour, red in the top byte
	typedef logic [23:0] rgb_t;

	// colours of all cells side by side, cell 0 in the low bits
	typedef rgb_t [board_cells-1:0] cell_rgb_t;

	// code to colour, index 0 on the right
	localparam rgb_t [3:0] palette = {
		24'hFF00FF,
		24'h00FFFF,
		24'hFFFF00,
		24'h202020
	};

	localparam rgb_t colour_line  = 24'hFFFFFF;
	localparam rgb_t colour_back  = 24'h000000;
	localparam rgb_t colour_win   = 24'h00FF00;
	localparam rgb_t colour_lose  = 24'hFF0000;
	// shown for any input combination the selector does not list
	localparam rgb_t colour_fault = 24'hA7A200;

endpackage

`default_nettype wire

//--- logic/vga_timing.sv
`timescale 1ns/1ps
`default_nettype none

module vga_timing (
	input  logic              clk,
	input  logic              arst_n,
	output video_pkg::scan_t  scan
);

	import video_pkg::*;

	logic [9:0] x_nxt;
	logic [9:0] y_nxt;

	// next raster position, x wraps every line and y every frame
	always_comb begin
		x_nxt = scan.x + 10'd1;
		y_nxt = scan.y;
		if (scan.x == 10'(h_total - 1)) begin
			x_nxt = '0;
			if (scan.y == 10'(v_total - 1)) begin
				y_nxt = '0;
			end else begin
				y_nxt = scan.y + 10'd1;
			end
		end
	end

	// flags come from the next position so they line up with x and y
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			scan.x      <= '0;
			scan.y      <= '0;
			scan.active <= 1'b1;
			scan.hsync  <= 1'b1;
			scan.vsync  <= 1'b1;
		end else begin
			scan.x      <= x_nxt;
			scan.y      <= y_nxt;
			scan.active <= (x_nxt < 10'(h_active)) && (y_nxt < 10'(v_active));
			scan.hsync  <= !((x_nxt >= 10'(h_sync_start)) && (x_nxt < 10'(h_sync_end)));
			scan.vsync  <= !((y_nxt >= 10'(v_sync_start)) && (y_nxt < 10'(v_sync_end)));
		end
	end

endmodule

`default_nettype wire

//--- logic/board_locator.sv
`timescale 1ns/1ps
`default_nettype none

module board_locator (
	input  logic                               clk,
	input  logic                               arst_n,
	input  video_pkg::scan_t                   scan,
	output video_pkg::scan_t                   scan_q,
	output logic                               line,
	output logic [board_pkg::board_cells-1:0]  pos
);

	import video_pkg::*;
	import board_pkg::*;

	// column state of the previous pixel, row state of the previous line
	logic [2:0] col_q;
	logic [5:0] xoff_q;
	logic [2:0] row_q;
	logic [5:0] yoff_q;

	// position of the pixel presented now
	logic [2:0] col_c;
	logic [5:0] xoff_c;
	logic [2:0] row_c;
	logic [5:0] yoff_c;

	logic                   in_board;
	logic                   line_c;
	logic [board_cells-1:0] pos_c;

	// horizontal step, restarts at the left board edge
	always_comb begin
		if (scan.x == 10'(board_x0)) begin
			col_c  = '0;
			xoff_c = '0;
		end else if (xoff_q == 6'(cell_px - 1)) begin
			col_c  = col_q + 3'd1;
			xoff_c = '0;
		end else begin
			col_c  = col_q;
			xoff_c = xoff_q + 6'd1;
		end
	end

	// vertical step, same scheme one line at a time
	always_comb begin
		if (scan.y == 10'(board_y0)) begin
			row_c  = '0;
			yoff_c = '0;
		end else if (yoff_q == 6'(cell_px - 1)) begin
			row_c  = row_q + 3'd1;
			yoff_c = '0;
		end else begin
			row_c  = row_q;
			yoff_c = yoff_q + 6'd1;
		end
	end

	always_comb begin
		in_board = (scan.x >= 10'(board_x0)) && (scan.x < 10'(board_x0 + board_span))
			&& (scan.y >= 10'(board_y0)) && (scan.y < 10'(board_y0 + board_span));
		line_c = in_board && ((xoff_c < 6'(line_px)) || (yoff_c < 6'(line_px)));
		pos_c  = '0;
		if (in_board && !line_c) begin
			pos_c[{row_c, col_c}] = 1'b1;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			col_q  <= '0;
			xoff_q <= '0;
			row_q  <= '0;
			yoff_q <= '0;
		end else begin
			col_q  <= col_c;
			xoff_q <= xoff_c;
			// row state moves on at the last pixel of each line
			if (scan.x == 10'(h_total - 1)) begin
				row_q  <= row_c;
				yoff_q <= yoff_c;
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			scan_q       <= '0;
			scan_q.hsync <= 1'b1;
			scan_q.vsync <= 1'b1;
			line         <= 1'b0;
			pos          <= '0;
		end else begin
			scan_q <= scan;
			line   <= line_c;
			pos    <= pos_c;
		end
	end

endmodule

`default_nettype wire

//--- logic/cell_store.sv
`timescale 1ns/1ps
`default_nettype none

module cell_store (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    cell_wr,
	input  logic [5:0]              cell_addr,
	input  board_pkg::cell_code_t   cell_code,
	output board_pkg::cell_rgb_t    cell_rgb
);

	import board_pkg::*;

	// one code per cell, index is row*8+column
	cell_code_t codes [board_cells];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < board_cells; i++) begin
				codes[i] <= '0;
			end
		end else if (cell_wr) begin
			codes[cell_addr] <= cell_code;
		end
	end

	// every cell goes through the palette at the same time
	always_comb begin
		for (int i = 0; i < board_cells; i++) begin
			cell_rgb[i] = palette[codes[i]];
		end
	end

endmodule

`default_nettype wire

//--- logic/draw_mux.sv
`timescale 1ns/1ps
`default_nettype none

module draw_mux (
	input  logic                               clk,
	input  logic                               arst_n,
	input  video_pkg::scan_t                   scan_q,
	input  logic                               line,
	input  logic [board_pkg::board_cells-1:0]  pos,
	input  board_pkg::cell_rgb_t               cell_rgb,
	input  logic                               win,
	input  logic                               lose,
	output video_pkg::pixel_t                  vga
);

	import board_pkg::*;

	// line in the top bit, then the cell vector, then win and lose
	logic [board_cells+2:0] sel;
	rgb_t                   colour;
	rgb_t                   colour_vis;

	assign sel = {line, pos, win, lose};

	// exact patterns only, so mixed inputs fall through to the olive colour
	always_comb begin
		colour = colour_fault;
		case (sel)
			{1'b0, {board_cells{1'b0}}, 2'b10}: colour = colour_win;
			{1'b0, {board_cells{1'b0}}, 2'b01}: colour = colour_lose;
			{1'b0, {board_cells{1'b0}}, 2'b00}: colour = colour_back;
			{1'b1, {board_cells{1'b0}}, 2'b00}: colour = colour_line;
			default: begin
				// a single cell bit on its own picks that cell
				for (int k = 0; k < board_cells; k++) begin
					if (sel == {1'b0, (board_cells'(1) << k), 2'b00}) begin
						colour = cell_rgb[k];
					end
				end
			end
		endcase
	end

	// nothing is driven outside the visible area
	assign colour_vis = scan_q.active ? colour : '0;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			vga.hsync <= 1'b1;
			vga.vsync <= 1'b1;
			vga.r     <= '0;
			vga.g     <= '0;
			vga.b     <= '0;
		end else begin
			vga.hsync <= scan_q.hsync;
			vga.vsync <= scan_q.vsync;
			vga.r     <= colour_vis[23:16];
			vga.g     <= colour_vis[15:8];
			vga.b     <= colour_vis[7:0];
		end
	end

endmodule

`default_nettype wire

//--- logic/game_display.sv
`timescale 1ns/1ps
`default_nettype none

module game_display (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   cell_wr,
	input  logic [5:0]             cell_addr,
	input  board_pkg::cell_code_t  cell_code,
	input  logic                   win,
	input  logic                   lose,
	output video_pkg::pixel_t      vga
);

	import video_pkg::*;
	import board_pkg::*;

	scan_t                  scan;
	scan_t                  scan_q;
	logic                   line;
	logic [board_cells-1:0] pos;
	cell_rgb_t              cell_rgb;

	// raster counters and syncs
	vga_timing u_timing (
		.clk    (clk),
		.arst_n (arst_n),
		.scan   (scan)
	);

	// grid line and cell lookup, one stage behind the counters
	board_locator u_locator (
		.clk    (clk),
		.arst_n (arst_n),
		.scan   (scan),
		.scan_q (scan_q),
		.line   (line),
		.pos    (pos)
	);

	cell_store u_cells (
		.clk       (clk),
		.arst_n    (arst_n),
		.cell_wr   (cell_wr),
		.cell_addr (cell_addr),
		.cell_code (cell_code),
		.cell_rgb  (cell_rgb)
	);

	draw_mux u_mux (
		.clk      (clk),
		.arst_n   (arst_n),
		.scan_q   (scan_q),
		.line     (line),
		.pos      (pos),
		.cell_rgb (cell_rgb),
		.win      (win),
		.lose     (lose),
		.vga      (vga)
	);

endmodule

`default_nettype wire

//--- tests/tb_pixel_model.svh
`ifndef TB_PIXEL_MODEL_SVH
`define TB_PIXEL_MODEL_SVH

// cell colours by code
localparam logic [23:0] palette_ref [4] = '{24'h202020, 24'hFFFF00, 24'h00FFFF, 24'hFF00FF};

// expected cell codes, index row*8+column
logic [1:0] shadow [64] = '{default: 2'b00};

logic [31:0] lcg_state = 32'd629;

function automatic logic [31:0] lcg_next();
	lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
	return lcg_state;
endfunction

// board at x 128 and y 48, 8 cells of 48 pixels, lines on the first 2 pixels of a cell
function automatic logic [23:0] expected_rgb(input int x, input int y, input logic w,
		input logic l);
	int dx;
	int dy;
	logic [5:0] idx;
	dx = x - 128;
	dy = y - 48;
	if (x >= 640 || y >= 480) begin
		return 24'h000000;
	end
	if (dx < 0 || dx >= 384 || dy < 0 || dy >= 384) begin
		case ({w, l})
			2'b00: return 24'h000000;
			2'b10: return 24'h00FF00;
			2'b01: return 24'hFF0000;
			default: return 24'hA7A200;
		endcase
	end
	// game state over a cell or a grid line matches no listed pattern
	if (w || l) begin
		return 24'hA7A200;
	end
	if ((dx % 48) < 2 || (dy % 48) < 2) begin
		return 24'hFFFFFF;
	end
	idx = 6'((dy / 48) * 8 + dx / 48);
	return palette_ref[shadow[idx]];
endfunction

`endif

//--- tests/tb_game_display.sv
`timescale 1ns/1ps
`default_nettype none

module tb_game_display;

	import video_pkg::*;

	logic        clk;
	logic        arst_n;
	logic        cell_wr;
	logic [5:0]  cell_addr;
	logic [1:0]  cell_code;
	logic        win;
	logic        lose;
	pixel_t      vga;

	// raster position of the pixel now on vga as found from the sync edges
	int          tx = 0;
	int          ty = 0;
	bit          hlock = 1'b0;
	bit          valid = 1'b0;
	logic        hs_prev = 1'b1;
	logic        vs_prev = 1'b1;
	int          hlow = 0;
	int          vlow = 0;
	string       phase = "board_geometry";
	string       blank_name = "blanking";
	logic [23:0] exp_rgb;
	logic [1:0]  code;

	`include "tb_pixel_model.svh"

	game_display dut0 (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic expect_count(input string name, input int exp, input int act);
		assert (act == exp)
			else fail_run($sformatf("mismatch %s: expected %0d, actual %0d", name, exp, act));
	endtask

	task automatic wait_for_pos(input int y, input int x);
		int n;
		n = 0;
		while (!(valid && ty == y && tx == x)) begin
			@(posedge clk);
			n = n + 1;
			if (n > 450000) begin
				fail_run($sformatf("timeout waiting for pixel x=%0d y=%0d", x, y));
			end
		end
	endtask

	always @(negedge clk) begin
		if (arst_n) begin
			tx = (tx == 799) ? 0 : tx + 1;
			if (tx == 0) begin
				ty = (ty == 524) ? 0 : ty + 1;
			end
			// hsync falls at x 656 and vsync at x 0 of line 490
			if (hs_prev && !vga.hsync) begin
				if (hlock) begin
					expect_count("hsync_period", 656, tx);
				end
				hlock = 1'b1;
				tx = 656;
			end
			if (vs_prev && !vga.vsync) begin
				if (valid) begin
					expect_count("vsync_period", 490, ty);
				end
				valid = 1'b1;
				ty = 490;
			end
			if (!vga.hsync) begin
				hlow = hlow + 1;
			end else if (!hs_prev) begin
				expect_count("hsync_width", 96, hlow);
				hlow = 0;
			end
			if (!vga.vsync) begin
				vlow = vlow + 1;
			end else if (!vs_prev) begin
				expect_count("vsync_width", 1600, vlow);
				vlow = 0;
			end
			if (valid) begin
				// sync levels follow the tracked position
				expect_count("hsync_level", (tx >= 656 && tx < 752) ? 0 : 1,
					int'(vga.hsync));
				expect_count("vsync_level", (ty == 490 || ty == 491) ? 0 : 1,
					int'(vga.vsync));
				exp_rgb = expected_rgb(tx, ty, win, lose);
				assert ({vga.r, vga.g, vga.b} == exp_rgb) else fail_run($sformatf(
					"mismatch %s at x=%0d y=%0d: expected %h, actual %h",
					(tx >= 640 || ty >= 480) ? blank_name : phase, tx, ty, exp_rgb,
					{vga.r, vga.g, vga.b}));
			end
			hs_prev = vga.hsync;
			vs_prev = vga.vsync;
		end
	end

	initial begin
		arst_n    = 1'b0;
		cell_wr   = 1'b0;
		cell_addr = 6'd0;
		cell_code = 2'd0;
		win       = 1'b0;
		lose      = 1'b0;
		repeat (8) @(posedge clk);
		assert (vga.hsync && vga.vsync && {vga.r, vga.g, vga.b} == 24'h000000)
			else fail_run("vga is not idle while reset is held");
		arst_n <= 1'b1;
		// tracking locks at the first vsync fall
		wait_for_pos(490, 0);
		// first frame runs on the reset codes and new codes go in during vblank
		wait_for_pos(480, 0);
		phase = "cell_colours";
		for (int i = 0; i < 64; i++) begin
			@(posedge clk);
			code = 2'(lcg_next() >> 16);
			cell_wr   <= 1'b1;
			cell_addr <= 6'(i);
			cell_code <= code;
			shadow[i] = code;
		end
		@(posedge clk);
		cell_wr <= 1'b0;
		wait_for_pos(480, 0);
		// third frame in bands of win, lose and both that switch in hblank
		phase = "game_state";
		win <= 1'b1;
		wait_for_pos(159, 700);
		win  <= 1'b0;
		lose <= 1'b1;
		wait_for_pos(319, 700);
		win <= 1'b1;
		wait_for_pos(480, 0);
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
+incdir+tests
logic/video_pkg.sv
logic/board_pkg.sv
logic/vga_timing.sv
logic/board_locator.sv
logic/cell_store.sv
logic/draw_mux.sv
logic/game_display.sv
tests/tb_game_display.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator and run it, the exit status is the result

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null; then
	echo "verilator not found"
	exit 1
fi

if ! verilator --binary --timing --assert --top-module tb_game_display -f flist.f; then
	echo "build failed"
	exit 1
fi

if ! ./obj_dir/Vtb_game_display; then
	echo "simulation failed"
	exit 1
fi

exit 0
